// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - include_dirs:
      - include
    files:
      - verilog/rv_pkg.sv
      - verilog/decoder.sv
      - verilog/regfile.sv
      - verilog/alu.sv
      - verilog/mdu.sv
      - verilog/exec_ctrl.sv
      - verilog/exec_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/exec_core_tb.sv

// ==== all.f ====
+incdir+include
verilog/rv_pkg.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/mdu.sv
verilog/exec_ctrl.sv
verilog/exec_core.sv
dv/exec_core_tb.sv

// ==== dv/exec_core_tb.sv ====
`include "rv_config.svh"

module exec_core_tb;
    import rv_pkg::*;

    typedef enum {
        OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND, OP_SLL, OP_SRL, OP_SRA,
        OP_SLT, OP_SLTU, OP_MUL, OP_DIV, OP_REM, OP_REMU
    } tb_op_e;

    // Reset checks twice, arith, shifts, word forms, muldiv, traps, back-pressure
    localparam int NUM_INSTR = 2 * 31 + 4 * 19 + 454 + 32 * 10 + 54 + 12 + 4;
    localparam int TIMEOUT   = NUM_INSTR * (`DIV_STEPS + 10);

    logic        clk = 1'b0;
    logic        rst_n;
    logic        issue_valid;
    issue_t      issue;
    logic        issue_ready;
    logic        retire_valid;
    retire_t     retire;
    logic        retire_ready;

    logic [63:0] shadow [32];  // Architectural register model
    logic [63:0] cur_pc = 64'h8000_0000;
    logic [31:0] lcg_state = 32'h6e6ed230;
    int          cycles = 0;
    int          value_errs = 0;
    int          handshake_errs = 0;

    exec_core u_exec_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_ready (retire_ready)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: the DUT did not retire everything within %0d cycles", TIMEOUT);
            $display("Test failed");
            $finish;
        end
    end

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [2:0] op_f3(input tb_op_e op);
        case (op)
            OP_SLL:        return FUNC3_SLL;
            OP_SLT:        return FUNC3_SLT;
            OP_SLTU:       return FUNC3_SLTU;
            OP_XOR:        return FUNC3_XOR;
            OP_DIV:        return FUNC3_DIV;
            OP_SRL, OP_SRA: return FUNC3_SRL;
            OP_OR:         return FUNC3_OR;
            OP_AND:        return FUNC3_AND;
            OP_REM:        return FUNC3_REM;
            OP_REMU:       return FUNC3_REMU;
            default:       return FUNC3_ADD;  // ADD, SUB, MUL
        endcase
    endfunction

    function automatic logic [6:0] op_f7(input tb_op_e op);
        case (op)
            OP_SUB, OP_SRA:                  return FUNC7_ALT;
            OP_MUL, OP_DIV, OP_REM, OP_REMU: return FUNC7_RVM;
            default:                         return FUNC7_ZERO;
        endcase
    endfunction

    // RV64IM result rules
    function automatic logic [63:0] model(input tb_op_e op, input logic word,
                                          input logic [63:0] a, input logic [63:0] b);
        logic [63:0] r;
        logic [5:0]  sh;
        logic        ovf;
        sh  = word ? {1'b0, b[4:0]} : b[5:0];
        ovf = (a == {1'b1, 63'b0}) && (b == '1);
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_XOR:  r = a ^ b;
            OP_OR:   r = a | b;
            OP_AND:  r = a & b;
            OP_SLL:  r = a << sh;
            OP_SRL:  r = word ? ({32'b0, a[31:0]} >> sh) : (a >> sh);
            OP_SRA:  r = word ? ($signed(sext32(a[31:0])) >>> sh) : ($signed(a) >>> sh);
            OP_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            OP_SLTU: r = (a < b) ? 64'd1 : 64'd0;
            OP_MUL:  r = a * b;
            OP_DIV: begin
                if (b == '0)
                    r = '1;
                else if (ovf)
                    r = a;
                else
                    r = $signed(a) / $signed(b);
            end
            OP_REM: begin
                if (b == '0)
                    r = a;
                else if (ovf)
                    r = '0;
                else
                    r = $signed(a) % $signed(b);
            end
            default: r = (b == '0) ? a : a % b;  // REMU
        endcase
        return word ? sext32(r[31:0]) : r;
    endfunction

    task automatic report_value(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
        value_errs++;
        $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic report_handshake(input string what);
        handshake_errs++;
        $display("Fail at %0t: %s", $time, what);
    endtask

    task automatic wait_accept();
        do @(negedge clk); while (!issue_ready);
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
        cur_pc      = cur_pc + 64'd4;
    endtask

    task automatic wait_retire();
        do @(negedge clk); while (!retire_valid);
    endtask

    // Sampled at a falling edge while retire_valid is high
    task automatic check_retire(input logic [4:0] rd, input logic [63:0] pc,
                                input logic [63:0] exp, input logic exp_trap);
        assert (retire.rd == rd) else report_value("retire.rd", retire.rd, rd);
        assert (retire.pc == pc) else report_value("retire.pc", retire.pc, pc);
        assert (retire.trap == exp_trap) else report_value("retire.trap", retire.trap, exp_trap);
        assert (retire.we == !exp_trap) else report_value("retire.we", retire.we, !exp_trap);
        if (!exp_trap) begin
            assert (retire.wdata == exp) else report_value("retire.wdata", retire.wdata, exp);
            if (rd != 5'd0)
                shadow[rd] = exp;
        end
    endtask

    task automatic issue_and_check(input logic [31:0] instr, input logic [63:0] exp,
                                   input logic exp_trap);
        logic [63:0] pc;
        pc          = cur_pc;
        issue.instr = instr;
        issue.pc    = pc;
        issue_valid = 1'b1;
        wait_accept();
        wait_retire();
        check_retire(instr[11:7], pc, exp, exp_trap);
        @(posedge clk);
        #1;
    endtask

    task automatic run_r(input tb_op_e op, input logic word, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        issue_and_check(enc_r(op_f7(op), rs2, rs1, op_f3(op), rd,
                              word ? OPCODE_RTYPEW : OPCODE_RTYPE),
                        model(op, word, shadow[rs1], shadow[rs2]), 1'b0);
    endtask

    task automatic run_i(input tb_op_e op, input logic word, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [11:0] imm);
        logic [11:0] field;
        logic [63:0] b;
        if (op == OP_SLL || op == OP_SRL || op == OP_SRA) begin
            field = {(op == OP_SRA) ? FUNC6_ARITH : FUNC6_LOGIC, imm[5:0]};
            b     = {58'b0, imm[5:0]};
        end else begin
            field = imm;
            b     = {{52{imm[11]}}, imm};
        end
        issue_and_check(enc_i(field, rs1, op_f3(op), rd, word ? OPCODE_ITYPEW : OPCODE_ITYPE),
                        model(op, word, shadow[rs1], b), 1'b0);
    endtask

    task automatic run_u(input logic [6:0] opc, input logic [4:0] rd, input logic [19:0] imm);
        logic [63:0] base;
        base = (opc == OPCODE_AUIPC) ? cur_pc : 64'd0;
        issue_and_check({imm, rd, opc}, base + sext32({imm, 12'b0}), 1'b0);
    endtask

    task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
        run_u(OPCODE_LUI, rd, v[31:12] + v[11]);  // Round up for the ADDI sign
        run_i(OP_ADD, 1'b0, rd, rd, v[11:0]);
    endtask

    task automatic test_reset();
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < 32; i++)
            shadow[i] = '0;
        @(negedge clk);
        assert (issue_ready) else report_handshake("issue_ready is low after reset");
        assert (!retire_valid) else report_handshake("retire_valid is high after reset");
        @(posedge clk);
        #1;
        for (int r = 1; r < 32; r++)
            run_i(OP_ADD, 1'b0, 5'(r), 5'(r), 12'd0);
    endtask

    task automatic test_arith();
        tb_op_e      ops [7] = '{OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND, OP_SLT, OP_SLTU};
        logic [31:0] rnd;
        repeat (4) begin
            load_reg(5'd1, next_rand());
            load_reg(5'd2, next_rand());
            foreach (ops[k]) begin
                run_r(ops[k], 1'b0, 5'd3, 5'd1, 5'd2);
                rnd = next_rand();
                if (ops[k] != OP_SUB)
                    run_i(ops[k], 1'b0, 5'd4, 5'd1, rnd[11:0]);
            end
            rnd = next_rand();
            run_u(OPCODE_LUI, 5'd5, rnd[31:12]);
            run_u(OPCODE_AUIPC, 5'd6, rnd[19:0]);
        end
    endtask

    task automatic test_shifts();
        load_reg(5'd1, next_rand());
        run_i(OP_SLL, 1'b0, 5'd1, 5'd1, 12'd19);
        load_reg(5'd2, next_rand());
        run_r(OP_XOR, 1'b0, 5'd1, 5'd1, 5'd2);  // Full 64-bit source
        for (int sh = 0; sh < 64; sh++) begin
            run_i(OP_ADD, 1'b0, 5'd2, 5'd0, 12'(sh));
            run_r(OP_SLL, 1'b0, 5'd3, 5'd1, 5'd2);
            run_r(OP_SRL, 1'b0, 5'd4, 5'd1, 5'd2);
            run_r(OP_SRA, 1'b0, 5'd5, 5'd1, 5'd2);
            run_i(OP_SLL, 1'b0, 5'd6, 5'd1, 12'(sh));
            run_i(OP_SRL, 1'b0, 5'd7, 5'd1, 12'(sh));
            run_i(OP_SRA, 1'b0, 5'd8, 5'd1, 12'(sh));
        end
    endtask

    task automatic test_word();
        logic [31:0] rnd;
        for (int sh = 0; sh < 32; sh++) begin
            rnd = next_rand();
            run_i(OP_ADD, 1'b0, 5'd2, 5'd0, {rnd[11:5], 5'(sh)});  // Junk above bit 4
            run_r(OP_SLL, 1'b1, 5'd3, 5'd1, 5'd2);
            run_r(OP_SRL, 1'b1, 5'd4, 5'd1, 5'd2);
            run_r(OP_SRA, 1'b1, 5'd5, 5'd1, 5'd2);
            run_r(OP_ADD, 1'b1, 5'd6, 5'd1, 5'd2);
            run_r(OP_SUB, 1'b1, 5'd7, 5'd1, 5'd2);
            run_i(OP_ADD, 1'b1, 5'd8, 5'd1, rnd[23:12]);
            run_i(OP_SLL, 1'b1, 5'd9, 5'd1, 12'(sh));
            run_i(OP_SRL, 1'b1, 5'd10, 5'd1, 12'(sh));
            run_i(OP_SRA, 1'b1, 5'd11, 5'd1, 12'(sh));
        end
    endtask

    task automatic test_muldiv();
        repeat (4) begin
            load_reg(5'd1, next_rand());
            load_reg(5'd2, next_rand());
            run_i(OP_SLL, 1'b0, 5'd8, 5'd1, 12'd29);
            run_r(OP_XOR, 1'b0, 5'd8, 5'd8, 5'd2);
            run_r(OP_MUL, 1'b0, 5'd3, 5'd8, 5'd2);
            run_r(OP_MUL, 1'b1, 5'd4, 5'd8, 5'd2);
            run_r(OP_DIV, 1'b0, 5'd5, 5'd8, 5'd2);
            run_r(OP_REM, 1'b0, 5'd6, 5'd8, 5'd2);
            run_r(OP_REMU, 1'b0, 5'd7, 5'd8, 5'd2);
        end
        run_r(OP_DIV, 1'b0, 5'd3, 5'd8, 5'd0);
        run_r(OP_REM, 1'b0, 5'd4, 5'd8, 5'd0);
        run_r(OP_REMU, 1'b0, 5'd5, 5'd8, 5'd0);
        // Most negative value over minus one
        run_u(OPCODE_LUI, 5'd9, 20'h80000);
        run_i(OP_SLL, 1'b0, 5'd9, 5'd9, 12'd32);
        run_i(OP_ADD, 1'b0, 5'd10, 5'd0, 12'hfff);
        run_r(OP_DIV, 1'b0, 5'd11, 5'd9, 5'd10);
        run_r(OP_REM, 1'b0, 5'd12, 5'd9, 5'd10);
        run_r(OP_DIV, 1'b0, 5'd13, 5'd9, 5'd0);
        run_r(OP_REM, 1'b0, 5'd14, 5'd9, 5'd0);
    endtask

    task automatic test_traps();
        logic [31:0] bad [5];
        bad[0] = enc_i(12'h010, 5'd1, 3'b011, 5'd5, 7'b0000011);          // LD
        bad[1] = enc_r(7'd0, 5'd2, 5'd1, 3'b011, 5'd5, 7'b0100011);       // SD
        bad[2] = enc_r(7'd0, 5'd2, 5'd1, 3'b000, 5'd5, 7'b1100011);       // BEQ
        bad[3] = {20'h00100, 5'd5, 7'b1101111};                            // JAL
        bad[4] = enc_r(7'b0000010, 5'd2, 5'd1, FUNC3_ADD, 5'd5, OPCODE_RTYPE);
        load_reg(5'd5, next_rand());
        foreach (bad[k]) begin
            issue_and_check(bad[k], '0, 1'b1);
            run_i(OP_ADD, 1'b0, 5'd5, 5'd5, 12'd0);  // rd must be unchanged
        end
    endtask

    task automatic test_backpressure();
        retire_t     held;
        logic [63:0] exp_a;
        logic [63:0] pc_a;
        logic [63:0] pc_b;
        run_i(OP_ADD, 1'b0, 5'd0, 5'd1, 12'd123);
        run_i(OP_ADD, 1'b0, 5'd6, 5'd0, 12'd0);
        retire_ready = 1'b0;
        exp_a        = shadow[6] + 64'd77;
        pc_a         = cur_pc;
        issue.instr  = enc_i(12'd77, 5'd6, FUNC3_ADD, 5'd6, OPCODE_ITYPE);
        issue.pc     = pc_a;
        issue_valid  = 1'b1;
        wait_accept();
        // Second instruction waits behind the stalled one
        pc_b         = cur_pc;
        issue.instr  = enc_i(12'd1, 5'd6, FUNC3_ADD, 5'd7, OPCODE_ITYPE);
        issue.pc     = pc_b;
        issue_valid  = 1'b1;
        wait_retire();
        held = retire;
        repeat (6) begin
            @(negedge clk);
            assert (retire_valid) else report_handshake("retire_valid dropped under back-pressure");
            assert (retire == held) else report_handshake("retire changed under back-pressure");
            assert (!issue_ready) else report_handshake("issue_ready high while retire is stalled");
        end
        check_retire(5'd6, pc_a, exp_a, 1'b0);
        @(posedge clk);
        #1;
        retire_ready = 1'b1;
        @(posedge clk);
        #1;
        wait_accept();
        wait_retire();
        check_retire(5'd7, pc_b, shadow[6] + 64'd1, 1'b0);
        @(posedge clk);
        #1;
    endtask

    initial begin
        rst_n        = 1'b0;
        issue_valid  = 1'b0;
        issue        = '0;
        retire_ready = 1'b1;
        test_reset();
        test_arith();
        test_shifts();
        test_word();
        test_muldiv();
        test_traps();
        test_backpressure();
        test_reset();
        $display("Errors: %0d value, %0d handshake", value_errs, handshake_errs);
        if (value_errs + handshake_errs == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== include/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

`define XLEN      64
`define NUM_REGS  32
`define DIV_STEPS `XLEN

`endif

// ==== verilog/alu.sv ====
`include "rv_config.svh"

module alu (
    input  rv_pkg::alu_op_t aluop,
    input  logic            is_word,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   result
);
    import rv_pkg::*;

    localparam int SHW = $clog2(`XLEN);

    logic [SHW-1:0] shamt;
    word_t          src_a;
    word_t          raw;

    always_comb begin
        shamt = is_word ? SHW'(b[4:0]) : b[SHW-1:0];
        // Word shifts see only the low half of the source
        if (!is_word)
            src_a = a;
        else if (aluop == ALU_SRA)
            src_a = {{(`XLEN-32){a[31]}}, a[31:0]};
        else
            src_a = {{(`XLEN-32){1'b0}}, a[31:0]};

        case (aluop)
            ALU_ADD:  raw = a + b;
            ALU_SUB:  raw = a - b;
            ALU_XOR:  raw = a ^ b;
            ALU_OR:   raw = a | b;
            ALU_AND:  raw = a & b;
            ALU_SLL:  raw = src_a << shamt;
            ALU_SRL:  raw = src_a >> shamt;
            ALU_SRA:  raw = $signed(src_a) >>> shamt;
            ALU_SLT:  raw = word_t'($signed(a) < $signed(b));
            ALU_SLTU: raw = word_t'(a < b);
            ALU_LUI:  raw = b;
            default:  raw = '0;
        endcase

        result = is_word ? {{(`XLEN-32){raw[31]}}, raw[31:0]} : raw;
    end

endmodule

// ==== verilog/decoder.sv ====
`include "rv_config.svh"

module decoder (
    input  rv_pkg::instr_u   raw_instr,
    output rv_pkg::word_t    imm,
    output rv_pkg::control_t ctl
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [6:0] f7;
    logic [5:0] f6;
    logic [2:0] f3;
    logic       is_w;
    logic       shamt_ok;

    assign opcode   = raw_instr.r.opcode;
    assign f7       = raw_instr.r.funct7;
    assign f6       = raw_instr.r.funct7[6:1];
    assign f3       = raw_instr.r.funct3;
    assign is_w     = (opcode == OPCODE_RTYPEW) || (opcode == OPCODE_ITYPEW);
    assign shamt_ok = !(is_w && f7[0]);  // Word shifts allow 5-bit amounts only

    always_comb begin
        ctl = '0;
        imm = {{(`XLEN-12){f7[6]}}, f7, raw_instr.r.rs2};  // I-type
        case (opcode)
            OPCODE_RTYPE, OPCODE_RTYPEW: begin
                ctl.is_word = is_w;
                case (f7)
                    FUNC7_ZERO: begin
                        case (f3)
                            FUNC3_ADD:  ctl.aluop = ALU_ADD;
                            FUNC3_SLL:  ctl.aluop = ALU_SLL;
                            FUNC3_SRL:  ctl.aluop = ALU_SRL;
                            FUNC3_SLT:  ctl.aluop = is_w ? ALU_NONE : ALU_SLT;
                            FUNC3_SLTU: ctl.aluop = is_w ? ALU_NONE : ALU_SLTU;
                            FUNC3_XOR:  ctl.aluop = is_w ? ALU_NONE : ALU_XOR;
                            FUNC3_OR:   ctl.aluop = is_w ? ALU_NONE : ALU_OR;
                            default:    ctl.aluop = is_w ? ALU_NONE : ALU_AND;
                        endcase
                    end
                    FUNC7_ALT: begin
                        case (f3)
                            FUNC3_ADD: ctl.aluop = ALU_SUB;
                            FUNC3_SRL: ctl.aluop = ALU_SRA;
                            default:   ctl.aluop = ALU_NONE;
                        endcase
                    end
                    FUNC7_RVM: begin
                        case (f3)
                            FUNC3_MUL:  ctl.mduop = MDU_MUL;  // MULW when is_word
                            FUNC3_DIV:  ctl.mduop = is_w ? MDU_NONE : MDU_DIV;
                            FUNC3_REM:  ctl.mduop = is_w ? MDU_NONE : MDU_REM;
                            FUNC3_REMU: ctl.mduop = is_w ? MDU_NONE : MDU_REMU;
                            default:    ctl.mduop = MDU_NONE;
                        endcase
                    end
                    default: ctl = '0;
                endcase
            end
            OPCODE_ITYPE, OPCODE_ITYPEW: begin
                ctl.is_imm  = 1'b1;
                ctl.is_word = is_w;
                case (f3)
                    FUNC3_ADD:  ctl.aluop = ALU_ADD;
                    FUNC3_SLT:  ctl.aluop = is_w ? ALU_NONE : ALU_SLT;
                    FUNC3_SLTU: ctl.aluop = is_w ? ALU_NONE : ALU_SLTU;
                    FUNC3_XOR:  ctl.aluop = is_w ? ALU_NONE : ALU_XOR;
                    FUNC3_OR:   ctl.aluop = is_w ? ALU_NONE : ALU_OR;
                    FUNC3_AND:  ctl.aluop = is_w ? ALU_NONE : ALU_AND;
                    FUNC3_SLL: begin
                        if (f6 == FUNC6_LOGIC && shamt_ok)
                            ctl.aluop = ALU_SLL;
                    end
                    default: begin
                        case (f6)
                            FUNC6_LOGIC: ctl.aluop = shamt_ok ? ALU_SRL : ALU_NONE;
                            FUNC6_ARITH: ctl.aluop = shamt_ok ? ALU_SRA : ALU_NONE;
                            default:     ctl.aluop = ALU_NONE;
                        endcase
                    end
                endcase
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                imm = {{(`XLEN-32){raw_instr.u.imm20[19]}}, raw_instr.u.imm20, 12'b0};
                ctl.is_imm = 1'b1;
                ctl.use_pc = (opcode == OPCODE_AUIPC);
                ctl.aluop  = (opcode == OPCODE_AUIPC) ? ALU_ADD : ALU_LUI;
            end
            default: ctl = '0;
        endcase
        ctl.reg_write = (ctl.aluop != ALU_NONE) || (ctl.mduop != MDU_NONE);
        if (!ctl.reg_write)
            ctl = '0;  // Not executable
    end

endmodule

// ==== verilog/exec_core.sv ====
module exec_core (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue_valid,
    input  rv_pkg::issue_t  issue,
    output logic            issue_ready,
    output logic            retire_valid,
    output rv_pkg::retire_t retire,
    input  logic            retire_ready
);
    import rv_pkg::*;

    control_t ctl;
    word_t    imm;
    word_t    rdata_a;
    word_t    rdata_b;
    alu_op_t  alu_aluop;
    logic     alu_word;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    logic     mdu_start;
    mdu_op_t  mdu_op;
    logic     mdu_word;
    word_t    mdu_a;
    word_t    mdu_b;
    logic     mdu_done;
    word_t    mdu_result;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    decoder u_decoder (
        .raw_instr (issue.instr),
        .imm       (imm),
        .ctl       (ctl)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (issue.instr.r.rs1),
        .raddr_b (issue.instr.r.rs2),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata)
    );

    alu u_alu (
        .aluop   (alu_aluop),
        .is_word (alu_word),
        .a       (alu_a),
        .b       (alu_b),
        .result  (alu_result)
    );

    mdu u_mdu (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mdu_start),
        .op      (mdu_op),
        .is_word (mdu_word),
        .a       (mdu_a),
        .b       (mdu_b),
        .done    (mdu_done),
        .result  (mdu_result)
    );

    exec_ctrl u_exec_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .ctl          (ctl),
        .imm          (imm),
        .rdata_a      (rdata_a),
        .rdata_b      (rdata_b),
        .alu_aluop    (alu_aluop),
        .alu_word     (alu_word),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_result   (alu_result),
        .mdu_start    (mdu_start),
        .mdu_op       (mdu_op),
        .mdu_word     (mdu_word),
        .mdu_a        (mdu_a),
        .mdu_b        (mdu_b),
        .mdu_done     (mdu_done),
        .mdu_result   (mdu_result),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_ready (retire_ready),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata)
    );

endmodule

// ==== verilog/exec_ctrl.sv ====
module exec_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             issue_valid,
    input  rv_pkg::issue_t   issue,
    output logic             issue_ready,
    input  rv_pkg::control_t ctl,
    input  rv_pkg::word_t    imm,
    input  rv_pkg::word_t    rdata_a,
    input  rv_pkg::word_t    rdata_b,
    output rv_pkg::alu_op_t  alu_aluop,
    output logic             alu_word,
    output rv_pkg::word_t    alu_a,
    output rv_pkg::word_t    alu_b,
    input  rv_pkg::word_t    alu_result,
    output logic             mdu_start,
    output rv_pkg::mdu_op_t  mdu_op,
    output logic             mdu_word,
    output rv_pkg::word_t    mdu_a,
    output rv_pkg::word_t    mdu_b,
    input  logic             mdu_done,
    input  rv_pkg::word_t    mdu_result,
    output logic             retire_valid,
    output rv_pkg::retire_t  retire,
    input  logic             retire_ready,
    output logic             rf_we,
    output rv_pkg::reg_idx_t rf_waddr,
    output rv_pkg::word_t    rf_wdata
);
    import rv_pkg::*;

    typedef enum logic [1:0] {IDLE, EXEC, MDU_WAIT, RETIRE} state_t;

    state_t   state;
    control_t ctl_q;
    word_t    pc_q;
    reg_idx_t rd_q;
    word_t    opa_q;
    word_t    opb_q;
    logic     accept;
    logic     finish;

    assign accept = issue_valid && issue_ready;
    assign finish = (state == EXEC && ctl_q.mduop == MDU_NONE) ||
                    (state == MDU_WAIT && mdu_done);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            mdu_start <= 1'b0;
        end else begin
            mdu_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept)
                        state <= EXEC;
                end
                EXEC: begin
                    if (ctl_q.mduop != MDU_NONE) begin
                        state     <= MDU_WAIT;
                        mdu_start <= 1'b1;  // One-cycle pulse
                    end else begin
                        state <= RETIRE;
                    end
                end
                MDU_WAIT: begin
                    if (mdu_done)
                        state <= RETIRE;
                end
                default: begin
                    if (retire_ready)
                        state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ctl_q <= ctl;
            pc_q  <= issue.pc;
            rd_q  <= issue.instr.r.rd;
            opa_q <= ctl.use_pc ? issue.pc : rdata_a;  // AUIPC adds to pc
            opb_q <= ctl.is_imm ? imm : rdata_b;
        end
        if (finish) begin
            retire.pc    <= pc_q;
            retire.rd    <= rd_q;
            retire.wdata <= (state == MDU_WAIT) ? mdu_result : alu_result;
            retire.we    <= ctl_q.reg_write;
            retire.trap  <= (ctl_q == '0);
        end
    end

    assign issue_ready  = (state == IDLE);
    assign retire_valid = (state == RETIRE);

    assign alu_aluop = ctl_q.aluop;
    assign alu_word  = ctl_q.is_word;
    assign alu_a     = opa_q;
    assign alu_b     = opb_q;
    assign mdu_op    = ctl_q.mduop;
    assign mdu_word  = ctl_q.is_word;
    assign mdu_a     = opa_q;
    assign mdu_b     = opb_q;

    assign rf_we    = retire_valid && retire_ready && retire.we;
    assign rf_waddr = retire.rd;
    assign rf_wdata = retire.wdata;

    a_retire_hold: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire));

endmodule

// ==== verilog/mdu.sv ====
`include "rv_config.svh"

module mdu (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  rv_pkg::mdu_op_t op,
    input  logic            is_word,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output logic            done,
    output rv_pkg::word_t   result
);
    import rv_pkg::*;

    localparam int CW = $clog2(`DIV_STEPS + 1);

    logic           busy;
    logic [CW-1:0]  count;
    mdu_op_t        op_q;
    logic           neg_q;
    word_t          prod_q;
    word_t          rem_q;
    word_t          quot_q;
    word_t          dvsr_q;
    word_t          prod;
    logic           sign_a;
    logic           sign_b;
    logic [`XLEN:0] trial;
    logic [`XLEN:0] diff;
    word_t          div_out;

    assign prod   = a * b;
    assign sign_a = (op == MDU_DIV || op == MDU_REM) && a[`XLEN-1];
    assign sign_b = (op == MDU_DIV || op == MDU_REM) && b[`XLEN-1];
    assign trial  = {rem_q, quot_q[`XLEN-1]};  // Partial remainder shifted
    assign diff   = trial - {1'b0, dvsr_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= (op != MDU_MUL);
                done  <= (op == MDU_MUL);  // Multiply finishes in one cycle
                count <= CW'(`DIV_STEPS);
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == CW'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_q   <= op;
            prod_q <= is_word ? {{(`XLEN-32){prod[31]}}, prod[31:0]} : prod;
            // Divide by zero keeps the all-ones quotient unsigned
            neg_q  <= (op == MDU_DIV) ? (sign_a ^ sign_b) && (b != '0) : sign_a;
            rem_q  <= '0;
            quot_q <= sign_a ? -a : a;
            dvsr_q <= sign_b ? -b : b;
        end else if (busy) begin
            rem_q  <= diff[`XLEN] ? trial[`XLEN-1:0] : diff[`XLEN-1:0];
            quot_q <= {quot_q[`XLEN-2:0], ~diff[`XLEN]};
        end
    end

    assign div_out = (op_q == MDU_DIV) ? quot_q : rem_q;
    assign result  = (op_q == MDU_MUL) ? prod_q : (neg_q ? -div_out : div_out);

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy);

endmodule

// ==== verilog/regfile.sv ====
`include "rv_config.svh"

module regfile (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t raddr_a,
    input  rv_pkg::reg_idx_t raddr_b,
    output rv_pkg::word_t    rdata_a,
    output rv_pkg::word_t    rdata_b,
    input  logic             we,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::word_t    wdata
);
    import rv_pkg::*;

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin  // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

// ==== verilog/rv_pkg.sv ====
`include "rv_config.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0]             word_t;
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

    localparam logic [6:0] OPCODE_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPCODE_ITYPE  = 7'b0010011;
    localparam logic [6:0] OPCODE_RTYPEW = 7'b0111011;
    localparam logic [6:0] OPCODE_ITYPEW = 7'b0011011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;

    localparam logic [2:0] FUNC3_ADD  = 3'b000;  // Also SUB, MUL
    localparam logic [2:0] FUNC3_SLL  = 3'b001;
    localparam logic [2:0] FUNC3_SLT  = 3'b010;
    localparam logic [2:0] FUNC3_SLTU = 3'b011;
    localparam logic [2:0] FUNC3_XOR  = 3'b100;  // Also DIV
    localparam logic [2:0] FUNC3_SRL  = 3'b101;  // Also SRA
    localparam logic [2:0] FUNC3_OR   = 3'b110;  // Also REM
    localparam logic [2:0] FUNC3_AND  = 3'b111;  // Also REMU

    localparam logic [2:0] FUNC3_MUL  = 3'b000;
    localparam logic [2:0] FUNC3_DIV  = 3'b100;
    localparam logic [2:0] FUNC3_REM  = 3'b110;
    localparam logic [2:0] FUNC3_REMU = 3'b111;

    localparam logic [6:0] FUNC7_ZERO = 7'b0000000;
    localparam logic [6:0] FUNC7_ALT  = 7'b0100000;  // SUB, SRA
    localparam logic [6:0] FUNC7_RVM  = 7'b0000001;

    localparam logic [5:0] FUNC6_LOGIC = 6'b000000;  // SLLI, SRLI
    localparam logic [5:0] FUNC6_ARITH = 6'b010000;  // SRAI

    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        MDU_NONE,
        MDU_MUL,
        MDU_DIV,
        MDU_REM,
        MDU_REMU
    } mdu_op_t;

    typedef struct packed {
        alu_op_t aluop;
        mdu_op_t mduop;
        logic    reg_write;
        logic    is_imm;
        logic    is_word;
        logic    use_pc;
    } control_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [19:0] imm20;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } instr_upper_t;

    typedef union packed {
        instr_r_t     r;
        instr_upper_t u;
    } instr_u;

    typedef struct packed {
        instr_u instr;
        word_t  pc;
    } issue_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        word_t    wdata;
        logic     we;
        logic     trap;
    } retire_t;

endpackage
